// File: alpha_id_config.svh
/* decode stage sizing: lane count, register file depth,
   datapath widths and the hard-wired zero register */
`ifndef ALPHA_ID_CONFIG_SVH
`define ALPHA_ID_CONFIG_SVH

// decode lanes per fetch bundle
`define ID_WIDTH 2

// architectural integer registers
`define NUM_REGS 32
`define XLEN     64  // register data width
`define PC_W     64  // next-pc width

// r31 always reads zero, writes to it vanish
`define ZERO_REG 31

`endif

// File: alpha_id_pkg.sv
/* opcodes, alpha function codes, alu and operand selects,
   and the three-view union over one instruction word */
`default_nettype none
`include "alpha_id_config.svh"

package alpha_id_pkg;

  localparam int IDX_W = $clog2(`NUM_REGS);
  localparam logic [IDX_W-1:0] ZERO_IDX = IDX_W'(`ZERO_REG);
  localparam logic [IDX_W-1:0] NO_DEST  = ZERO_IDX;  // dest of r31 means none

  //////////////////////////////////////////////////
  // major opcodes recognised by the decoder
  typedef enum logic [5:0] {
    OP_PAL   = 6'h00, OP_LDA  = 6'h08,
    OP_INTA  = 6'h10, OP_INTL = 6'h11, OP_INTS = 6'h12, OP_INTM = 6'h13,
    OP_JSR   = 6'h1a,  // jmp group, hint in disp[15:14]
    OP_LDQ   = 6'h29, OP_LDQ_L = 6'h2b, OP_STQ = 6'h2d, OP_STQ_C = 6'h2f,
    OP_BR    = 6'h30, OP_BSR  = 6'h34,
    OP_BLBC  = 6'h38, OP_BEQ  = 6'h39, OP_BLT  = 6'h3a, OP_BLE  = 6'h3b,
    OP_BLBS  = 6'h3c, OP_BNE  = 6'h3d, OP_BGE  = 6'h3e, OP_BGT  = 6'h3f
  } op_e;

  // 7-bit operate functions, values repeat across the four groups
  localparam logic [6:0] FN_ADDQ  = 7'h20, FN_SUBQ   = 7'h29, FN_CMPEQ  = 7'h2d;
  localparam logic [6:0] FN_CMPLT = 7'h4d, FN_CMPLE  = 7'h6d, FN_CMPULT = 7'h1d;
  localparam logic [6:0] FN_CMPULE = 7'h3d;
  localparam logic [6:0] FN_AND   = 7'h00, FN_BIC   = 7'h08, FN_BIS   = 7'h20;
  localparam logic [6:0] FN_ORNOT = 7'h28, FN_XOR   = 7'h40, FN_EQV   = 7'h48;
  localparam logic [6:0] FN_SRL   = 7'h34, FN_SLL   = 7'h39, FN_SRA   = 7'h3c;
  localparam logic [6:0] FN_MULQ  = 7'h20;

  // call_pal functions, low 26 bits of the word
  localparam logic [25:0] PAL_HALT  = 26'h0000000;
  localparam logic [25:0] PAL_CPUID = 26'h000003c;

  //////////////////////////////////////////////////
  // execute-side encodings
  typedef enum logic [4:0] {
    ALU_ADDQ, ALU_SUBQ, ALU_AND, ALU_BIC, ALU_BIS, ALU_ORNOT,
    ALU_XOR, ALU_EQV, ALU_SRL, ALU_SLL, ALU_SRA, ALU_MULQ,
    ALU_CMPEQ, ALU_CMPLT, ALU_CMPLE, ALU_CMPULT, ALU_CMPULE
  } alu_func_e;

  typedef enum logic [1:0] {
    OPA_REG, OPA_MEM_DISP, OPA_NPC, OPA_NOT_USED
  } opa_sel_e;

  typedef enum logic [2:0] {
    OPB_REG, OPB_LIT, OPB_MEM_DISP, OPB_BR_DISP, OPB_UBR_DISP
  } opb_sel_e;

  //////////////////////////////////////////////////
  // instruction word, one view per format
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [15:0] disp;
  } mem_fmt_t;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] ra;
    union packed {
      struct packed {
        logic [4:0] rb;
        logic [2:0] sbz;
      } r;                // register form
      logic [7:0] lit;    // literal form, same bits
    } b;
    logic       lit_flag;
    logic [6:0] func;
    logic [4:0] rc;
  } op_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [20:0] disp;  // longword displacement
  } br_fmt_t;

  typedef union packed {
    mem_fmt_t mem;
    op_fmt_t  op;
    br_fmt_t  br;
  } alpha_inst_u;

endpackage
`default_nettype wire

// File: fetch_latch.sv
/* if/id register: holds the fetch bundle under stall,
   drops its valid bits on flush */
`timescale 1ns/1ns
`default_nettype none
`include "alpha_id_config.svh"

module fetch_latch
  import alpha_id_pkg::*;
(
  input  wire                               clock,
  input  wire                               rst_n,
  input  wire                               stall,     // hold the bundle
  input  wire                               flush,     // kill the bundle, beats stall
  input  wire        [`ID_WIDTH-1:0]        if_valid,
  input  wire alpha_inst_u [`ID_WIDTH-1:0]  if_inst,
  input  wire        [`ID_WIDTH-1:0][`PC_W-1:0] if_npc,
  output logic       [`ID_WIDTH-1:0]        dec_valid,
  output alpha_inst_u [`ID_WIDTH-1:0]       dec_inst,
  output logic       [`ID_WIDTH-1:0][`PC_W-1:0] dec_npc
);

  //////////////////////////////////////////////////
  // valid bits, the only control state here
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= '0;
    end else if (flush) begin
      dec_valid <= '0;             // bubble every lane
    end else if (!stall) begin
      dec_valid <= if_valid;
    end
  end

  // payload follows the valid bits but keeps its value on flush
  always_ff @(posedge clock) begin
    if (!stall && !flush) begin
      dec_inst <= if_inst;
      dec_npc  <= if_npc;
    end
  end

endmodule
`default_nettype wire

// File: inst_decoder.sv
/* one decode lane: instruction word to alu controls,
   memory and branch flags, and register indices */
`timescale 1ns/1ns
`default_nettype none

module inst_decoder
  import alpha_id_pkg::*;
(
  input  wire               valid,
  input  wire alpha_inst_u  inst,
  output opa_sel_e          opa_select,
  output opb_sel_e          opb_select,
  output alu_func_e         alu_func,
  output logic              rd_mem,
  output logic              wr_mem,
  output logic              ldl_mem,        // load-locked
  output logic              stc_mem,        // store-conditional
  output logic              cond_branch,
  output logic              uncond_branch,
  output logic              halt,
  output logic              cpuid,
  output logic              illegal,
  output logic [IDX_W-1:0]  dest_idx,
  output logic [IDX_W-1:0]  rega_idx,       // read port a
  output logic [IDX_W-1:0]  regb_idx,       // read port b
  output logic              dec_valid
);

  logic        bad;       // opcode or function not recognised
  logic [25:0] pal_func;

  assign pal_func = {inst.mem.ra, inst.mem.rb, inst.mem.disp};

  always_comb begin
    opa_select = OPA_NOT_USED;
    opb_select = OPB_REG;
    alu_func   = ALU_ADDQ;
    {rd_mem, wr_mem, ldl_mem, stc_mem} = '0;
    {cond_branch, uncond_branch, halt, cpuid} = '0;
    dest_idx   = NO_DEST;
    rega_idx   = inst.op.ra;      // operate view by default
    regb_idx   = inst.op.b.r.rb;
    bad        = 1'b0;

    case (inst.mem.opcode)
      OP_PAL: begin
        halt  = (pal_func == PAL_HALT);
        cpuid = (pal_func == PAL_CPUID);
        bad   = !(halt || cpuid);
      end

      //////////////////////////////////////////////////
      // memory format, base rb goes out on port a
      OP_LDA, OP_LDQ, OP_LDQ_L: begin
        opa_select = OPA_REG;
        opb_select = OPB_MEM_DISP;
        rega_idx   = inst.mem.rb;
        dest_idx   = inst.mem.ra;
        rd_mem     = (inst.mem.opcode != OP_LDA);   // lda only forms the address
        ldl_mem    = (inst.mem.opcode == OP_LDQ_L);
      end
      OP_STQ, OP_STQ_C: begin
        opa_select = OPA_REG;
        opb_select = OPB_MEM_DISP;
        rega_idx   = inst.mem.rb;
        regb_idx   = inst.mem.ra;                   // store data on port b
        wr_mem     = 1'b1;
        stc_mem    = (inst.mem.opcode == OP_STQ_C);
      end

      //////////////////////////////////////////////////
      // operate format, group from opcode[1:0]
      OP_INTA, OP_INTL, OP_INTS, OP_INTM: begin
        opa_select = OPA_REG;
        opb_select = inst.op.lit_flag ? OPB_LIT : OPB_REG;
        regb_idx   = inst.op.lit_flag ? ZERO_IDX : inst.op.b.r.rb;
        dest_idx   = inst.op.rc;
        case ({inst.op.opcode[1:0], inst.op.func})
          {2'd0, FN_ADDQ}:   alu_func = ALU_ADDQ;
          {2'd0, FN_SUBQ}:   alu_func = ALU_SUBQ;
          {2'd0, FN_CMPEQ}:  alu_func = ALU_CMPEQ;
          {2'd0, FN_CMPLT}:  alu_func = ALU_CMPLT;
          {2'd0, FN_CMPLE}:  alu_func = ALU_CMPLE;
          {2'd0, FN_CMPULT}: alu_func = ALU_CMPULT;
          {2'd0, FN_CMPULE}: alu_func = ALU_CMPULE;
          {2'd1, FN_AND}:    alu_func = ALU_AND;
          {2'd1, FN_BIC}:    alu_func = ALU_BIC;
          {2'd1, FN_BIS}:    alu_func = ALU_BIS;
          {2'd1, FN_ORNOT}:  alu_func = ALU_ORNOT;
          {2'd1, FN_XOR}:    alu_func = ALU_XOR;
          {2'd1, FN_EQV}:    alu_func = ALU_EQV;
          {2'd2, FN_SRL}:    alu_func = ALU_SRL;
          {2'd2, FN_SLL}:    alu_func = ALU_SLL;
          {2'd2, FN_SRA}:    alu_func = ALU_SRA;
          {2'd3, FN_MULQ}:   alu_func = ALU_MULQ;
          default:           bad = 1'b1;
        endcase
      end

      // jmp only, jsr / ret / coroutine hints are not decoded
      OP_JSR: begin
        bad           = (inst.mem.disp[15:14] != 2'b00);
        alu_func      = ALU_AND;        // execute masks rb with ~3 on side a
        dest_idx      = inst.mem.ra;
        uncond_branch = 1'b1;
      end

      //////////////////////////////////////////////////
      // branch format, target = npc + 4*disp
      OP_BR, OP_BSR: begin
        opa_select    = OPA_NPC;
        opb_select    = OPB_UBR_DISP;
        regb_idx      = ZERO_IDX;
        dest_idx      = inst.br.ra;     // link register
        uncond_branch = 1'b1;
      end
      OP_BLBC, OP_BEQ, OP_BLT, OP_BLE, OP_BLBS, OP_BNE, OP_BGE, OP_BGT: begin
        opa_select  = OPA_NPC;
        opb_select  = OPB_BR_DISP;
        rega_idx    = inst.br.ra;       // tested value
        regb_idx    = ZERO_IDX;
        cond_branch = 1'b1;
      end
      default: bad = 1'b1;
    endcase

    // bubbles and unknown words must never act downstream
    if (!valid || bad) begin
      {rd_mem, wr_mem, ldl_mem, stc_mem} = '0;
      {cond_branch, uncond_branch, halt, cpuid} = '0;
      dest_idx = NO_DEST;
    end
    illegal   = valid && bad;
    dec_valid = valid && !bad;
  end

endmodule
`default_nettype wire

// File: regfile.sv
/* integer register file: two read ports per lane, one write port,
   r31 hard-wired to zero, same-cycle write forwarded to readers */
`timescale 1ns/1ns
`default_nettype none
`include "alpha_id_config.svh"

module regfile
  import alpha_id_pkg::*;
(
  input  wire                                   clock,
  input  wire                                   rst_n,
  input  wire  [2*`ID_WIDTH-1:0][IDX_W-1:0]     rd_idx,   // lane i uses 2i and 2i+1
  output logic [2*`ID_WIDTH-1:0][`XLEN-1:0]     rd_data,
  input  wire                                   wb_en,
  input  wire  [IDX_W-1:0]                      wb_idx,
  input  wire  [`XLEN-1:0]                      wb_data
);

  logic [`XLEN-1:0] regs [0:`NUM_REGS-2];   // no storage behind r31
  logic             wb_live;                // a write that actually lands

  assign wb_live = wb_en && (wb_idx != ZERO_IDX);

  //////////////////////////////////////////////////
  // write port
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < `NUM_REGS - 1; r++) begin
        regs[r] <= '0;
      end
    end else if (wb_live) begin
      regs[wb_idx] <= wb_data;
    end
  end

  // read ports with bypass
  always_comb begin
    for (int p = 0; p < 2 * `ID_WIDTH; p++) begin
      if (rd_idx[p] == ZERO_IDX)
        rd_data[p] = '0;
      else if (wb_live && wb_idx == rd_idx[p])
        rd_data[p] = wb_data;                 // write in flight this cycle
      else
        rd_data[p] = regs[rd_idx[p]];
    end
  end

endmodule
`default_nettype wire

// File: id_ex_reg.sv
/* id/ex register that captures every decoded lane with its operand
   values and clears the control bits of a bubble */
`timescale 1ns/1ns
`default_nettype none
`include "alpha_id_config.svh"

module id_ex_reg
  import alpha_id_pkg::*;
(
  input  wire                                    clock,
  input  wire                                    rst_n,
  input  wire                                    stall,
  input  wire                                    flush,
  input  wire  [`ID_WIDTH-1:0]                   id_valid,
  input  wire  [`ID_WIDTH-1:0][`PC_W-1:0]        id_npc,
  input  wire alpha_inst_u [`ID_WIDTH-1:0]       id_inst,
  input  wire opa_sel_e  [`ID_WIDTH-1:0]         id_opa_select,
  input  wire opb_sel_e  [`ID_WIDTH-1:0]         id_opb_select,
  input  wire alu_func_e [`ID_WIDTH-1:0]         id_alu_func,
  input  wire  [`ID_WIDTH-1:0]                   id_rd_mem, id_wr_mem, id_ldl_mem, id_stc_mem,
  input  wire  [`ID_WIDTH-1:0]                   id_cond_branch, id_uncond_branch,
  input  wire  [`ID_WIDTH-1:0]                   id_halt, id_cpuid, id_illegal,
  input  wire  [`ID_WIDTH-1:0][IDX_W-1:0]        id_dest_idx,
  input  wire  [`ID_WIDTH-1:0][`XLEN-1:0]        id_rega_value, id_regb_value,
  output logic [`ID_WIDTH-1:0]                   ex_valid,
  output logic [`ID_WIDTH-1:0][`PC_W-1:0]        ex_npc,
  output alpha_inst_u [`ID_WIDTH-1:0]            ex_inst,
  output opa_sel_e  [`ID_WIDTH-1:0]              ex_opa_select,
  output opb_sel_e  [`ID_WIDTH-1:0]              ex_opb_select,
  output alu_func_e [`ID_WIDTH-1:0]              ex_alu_func,
  output logic [`ID_WIDTH-1:0]                   ex_rd_mem, ex_wr_mem, ex_ldl_mem, ex_stc_mem,
  output logic [`ID_WIDTH-1:0]                   ex_cond_branch, ex_uncond_branch,
  output logic [`ID_WIDTH-1:0]                   ex_halt, ex_cpuid, ex_illegal,
  output logic [`ID_WIDTH-1:0][IDX_W-1:0]        ex_dest_idx,
  output logic [`ID_WIDTH-1:0][`XLEN-1:0]        ex_rega_value, ex_regb_value
);

  //////////////////////////////////////////////////
  // a bubble clears every control bit
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      {ex_valid, ex_rd_mem, ex_wr_mem, ex_ldl_mem, ex_stc_mem, ex_cond_branch,
       ex_uncond_branch, ex_halt, ex_cpuid, ex_illegal} <= '0;
    end else if (flush) begin
      {ex_valid, ex_rd_mem, ex_wr_mem, ex_ldl_mem, ex_stc_mem, ex_cond_branch,
       ex_uncond_branch, ex_halt, ex_cpuid, ex_illegal} <= '0;   // flush beats stall
    end else if (!stall) begin
      {ex_valid, ex_rd_mem, ex_wr_mem, ex_ldl_mem, ex_stc_mem, ex_cond_branch,
       ex_uncond_branch, ex_halt, ex_cpuid, ex_illegal} <=
      {id_valid, id_rd_mem, id_wr_mem, id_ldl_mem, id_stc_mem, id_cond_branch,
       id_uncond_branch, id_halt, id_cpuid, id_illegal};
    end
  end

  // payload fields of each lane
  always_ff @(posedge clock) begin
    if (!stall) begin
      ex_npc        <= id_npc;
      ex_inst       <= id_inst;
      ex_opa_select <= id_opa_select;
      ex_opb_select <= id_opb_select;
      ex_alu_func   <= id_alu_func;
      ex_dest_idx   <= id_dest_idx;
      ex_rega_value <= id_rega_value;
      ex_regb_value <= id_regb_value;
    end
  end

endmodule
`default_nettype wire

// File: id_stage.sv
/* decode stage top: fetch latch, decode lanes,
   shared register file and id/ex register */
`timescale 1ns/1ns
`default_nettype none
`include "alpha_id_config.svh"

module id_stage
  import alpha_id_pkg::*;
(
  input  wire                                    clock,
  input  wire                                    rst_n,
  input  wire                                    stall,
  input  wire                                    flush,
  input  wire  [`ID_WIDTH-1:0]                   if_valid,
  input  wire alpha_inst_u [`ID_WIDTH-1:0]       if_inst,
  input  wire  [`ID_WIDTH-1:0][`PC_W-1:0]        if_npc,
  input  wire                                    wb_en,
  input  wire  [IDX_W-1:0]                       wb_idx,
  input  wire  [`XLEN-1:0]                       wb_data,
  output logic [`ID_WIDTH-1:0]                   ex_valid,
  output logic [`ID_WIDTH-1:0][`PC_W-1:0]        ex_npc,
  output alpha_inst_u [`ID_WIDTH-1:0]            ex_inst,
  output opa_sel_e  [`ID_WIDTH-1:0]              ex_opa_select,
  output opb_sel_e  [`ID_WIDTH-1:0]              ex_opb_select,
  output alu_func_e [`ID_WIDTH-1:0]              ex_alu_func,
  output logic [`ID_WIDTH-1:0]                   ex_rd_mem, ex_wr_mem, ex_ldl_mem, ex_stc_mem,
  output logic [`ID_WIDTH-1:0]                   ex_cond_branch, ex_uncond_branch,
  output logic [`ID_WIDTH-1:0]                   ex_halt, ex_cpuid, ex_illegal,
  output logic [`ID_WIDTH-1:0][IDX_W-1:0]        ex_dest_idx,
  output logic [`ID_WIDTH-1:0][`XLEN-1:0]        ex_rega_value, ex_regb_value
);

  logic        [`ID_WIDTH-1:0]            dec_valid;     // from the fetch latch
  alpha_inst_u [`ID_WIDTH-1:0]            dec_inst;
  logic        [`ID_WIDTH-1:0][`PC_W-1:0] dec_npc;

  opa_sel_e  [`ID_WIDTH-1:0] lane_opa;
  opb_sel_e  [`ID_WIDTH-1:0] lane_opb;
  alu_func_e [`ID_WIDTH-1:0] lane_alu;
  logic [`ID_WIDTH-1:0] lane_rd, lane_wr, lane_ldl, lane_stc, lane_cbr, lane_ubr;
  logic [`ID_WIDTH-1:0] lane_halt, lane_cpuid, lane_illegal, lane_valid;
  logic [`ID_WIDTH-1:0][IDX_W-1:0]   lane_dest;
  logic [2*`ID_WIDTH-1:0][IDX_W-1:0] rd_idx;           // a on 2i, b on 2i+1
  logic [2*`ID_WIDTH-1:0][`XLEN-1:0] rd_data;
  logic [`ID_WIDTH-1:0][`XLEN-1:0]   rega_value, regb_value;

  fetch_latch u_fetch_latch (
    .clock, .rst_n, .stall, .flush, .if_valid, .if_inst, .if_npc,
    .dec_valid, .dec_inst, .dec_npc
  );

  //////////////////////////////////////////////////
  // one decoder per bundle slot
  for (genvar i = 0; i < `ID_WIDTH; i++) begin : g_lane
    inst_decoder u_dec (
      .valid(dec_valid[i]), .inst(dec_inst[i]),
      .opa_select(lane_opa[i]), .opb_select(lane_opb[i]), .alu_func(lane_alu[i]),
      .rd_mem(lane_rd[i]), .wr_mem(lane_wr[i]), .ldl_mem(lane_ldl[i]), .stc_mem(lane_stc[i]),
      .cond_branch(lane_cbr[i]), .uncond_branch(lane_ubr[i]),
      .halt(lane_halt[i]), .cpuid(lane_cpuid[i]), .illegal(lane_illegal[i]),
      .dest_idx(lane_dest[i]), .rega_idx(rd_idx[2*i]), .regb_idx(rd_idx[2*i+1]),
      .dec_valid(lane_valid[i])
    );
    assign rega_value[i] = rd_data[2*i];
    assign regb_value[i] = rd_data[2*i+1];
  end

  regfile u_regfile (
    .clock, .rst_n, .rd_idx, .rd_data, .wb_en, .wb_idx, .wb_data
  );

  id_ex_reg u_id_ex_reg (
    .clock, .rst_n, .stall, .flush,
    .id_valid(lane_valid), .id_npc(dec_npc), .id_inst(dec_inst),
    .id_opa_select(lane_opa), .id_opb_select(lane_opb), .id_alu_func(lane_alu),
    .id_rd_mem(lane_rd), .id_wr_mem(lane_wr), .id_ldl_mem(lane_ldl), .id_stc_mem(lane_stc),
    .id_cond_branch(lane_cbr), .id_uncond_branch(lane_ubr),
    .id_halt(lane_halt), .id_cpuid(lane_cpuid), .id_illegal(lane_illegal),
    .id_dest_idx(lane_dest), .id_rega_value(rega_value), .id_regb_value(regb_value),
    .ex_valid, .ex_npc, .ex_inst, .ex_opa_select, .ex_opb_select, .ex_alu_func,
    .ex_rd_mem, .ex_wr_mem, .ex_ldl_mem, .ex_stc_mem, .ex_cond_branch, .ex_uncond_branch,
    .ex_halt, .ex_cpuid, .ex_illegal, .ex_dest_idx, .ex_rega_value, .ex_regb_value
  );

endmodule
`default_nettype wire

// File: tb_id_stage.sv
/* decode stage testbench that replays the stimulus file under lfsr-driven
   stall and checks every lane of the id/ex register */
`timescale 1ns/1ns
`default_nettype none
`include "alpha_id_config.svh"

module tb_id_stage
  import alpha_id_pkg::*;
;

  logic                                  clock, rst_n, stall, flush;
  logic        [`ID_WIDTH-1:0]            if_valid;
  alpha_inst_u [`ID_WIDTH-1:0]            if_inst;
  logic        [`ID_WIDTH-1:0][`PC_W-1:0] if_npc;
  logic                                  wb_en;
  logic        [IDX_W-1:0]                wb_idx;
  logic        [`XLEN-1:0]                wb_data;
  logic        [`ID_WIDTH-1:0]            ex_valid, ex_rd_mem, ex_wr_mem, ex_ldl_mem, ex_stc_mem;
  logic        [`ID_WIDTH-1:0]            ex_cond_branch, ex_uncond_branch;
  logic        [`ID_WIDTH-1:0]            ex_halt, ex_cpuid, ex_illegal;
  logic        [`ID_WIDTH-1:0][`PC_W-1:0] ex_npc;
  alpha_inst_u [`ID_WIDTH-1:0]            ex_inst;
  opa_sel_e    [`ID_WIDTH-1:0]            ex_opa_select;
  opb_sel_e    [`ID_WIDTH-1:0]            ex_opb_select;
  alu_func_e   [`ID_WIDTH-1:0]            ex_alu_func;
  logic        [`ID_WIDTH-1:0][IDX_W-1:0] ex_dest_idx;
  logic        [`ID_WIDTH-1:0][`XLEN-1:0] ex_rega_value, ex_regb_value;

  // expected lane contents with one slot per lane
  logic             e_in_valid [`ID_WIDTH];
  logic [31:0]      e_inst     [`ID_WIDTH];
  logic [`PC_W-1:0] e_npc      [`ID_WIDTH];
  alu_func_e        e_alu      [`ID_WIDTH];
  opa_sel_e         e_opa      [`ID_WIDTH];
  opb_sel_e         e_opb      [`ID_WIDTH];
  logic [IDX_W-1:0] e_dest     [`ID_WIDTH];
  logic [8:0]       e_flags    [`ID_WIDTH];  // ill cpuid halt ubr cbr stc ldl wr rd
  logic [`XLEN-1:0] e_rega     [`ID_WIDTH];
  logic [`XLEN-1:0] e_regb     [`ID_WIDTH];

  int               fd, errors, n_test, n_pass, n_fail, err_mark;
  logic [31:0]      lfsr;
  logic             byp_pend, flush_next;   // pending bypass write and pending flush
  logic [IDX_W-1:0] byp_idx;
  logic [`XLEN-1:0] byp_data;
  logic [63:0]      kind;

  id_stage dut (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  //////////////////////////////////////////////////
  // stall stretches come from a fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function logic rand_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  function int stall_stretch();   // 0..3 stalled cycles
    int hi;
    hi = rand_bit();
    return 2 * hi + rand_bit();
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  task automatic check_alu(input string name, input alu_func_e exp, input alu_func_e act);
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s exp=%0d got=%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_opa_sel(input string name, input opa_sel_e exp, input opa_sel_e act);
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s exp=%0d got=%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_opb_sel(input string name, input opb_sel_e exp, input opb_sel_e act);
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s exp=%0d got=%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_idx(input string name, input logic [IDX_W-1:0] exp,
                           input logic [IDX_W-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s exp=%0d got=%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
                            input logic [`XLEN-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s exp=%h got=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s exp=%0b got=%0b", $time, name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // per-lane checks against the expected record
  task automatic check_lane(input int l);
    logic exp_v;
    exp_v = e_in_valid[l] && !e_flags[l][8];   // illegal words never go valid
    check_flag($sformatf("ex_valid[%0d]", l), exp_v, ex_valid[l]);
    check_flag($sformatf("ex_illegal[%0d]", l), e_flags[l][8], ex_illegal[l]);
    check_flag($sformatf("ex_cpuid[%0d]", l), e_flags[l][7], ex_cpuid[l]);
    check_flag($sformatf("ex_halt[%0d]", l), e_flags[l][6], ex_halt[l]);
    check_flag($sformatf("ex_uncond_branch[%0d]", l), e_flags[l][5], ex_uncond_branch[l]);
    check_flag($sformatf("ex_cond_branch[%0d]", l), e_flags[l][4], ex_cond_branch[l]);
    check_flag($sformatf("ex_stc_mem[%0d]", l), e_flags[l][3], ex_stc_mem[l]);
    check_flag($sformatf("ex_ldl_mem[%0d]", l), e_flags[l][2], ex_ldl_mem[l]);
    check_flag($sformatf("ex_wr_mem[%0d]", l), e_flags[l][1], ex_wr_mem[l]);
    check_flag($sformatf("ex_rd_mem[%0d]", l), e_flags[l][0], ex_rd_mem[l]);
    check_idx($sformatf("ex_dest_idx[%0d]", l), e_dest[l], ex_dest_idx[l]);
    if (exp_v) begin                            // payload only meaningful when valid
      check_alu($sformatf("ex_alu_func[%0d]", l), e_alu[l], ex_alu_func[l]);
      check_opa_sel($sformatf("ex_opa_select[%0d]", l), e_opa[l], ex_opa_select[l]);
      check_opb_sel($sformatf("ex_opb_select[%0d]", l), e_opb[l], ex_opb_select[l]);
      check_word($sformatf("ex_npc[%0d]", l), e_npc[l], ex_npc[l]);
      check_word($sformatf("ex_inst[%0d]", l), `XLEN'(e_inst[l]), `XLEN'(ex_inst[l]));
      check_word($sformatf("ex_rega_value[%0d]", l), e_rega[l], ex_rega_value[l]);
      check_word($sformatf("ex_regb_value[%0d]", l), e_regb[l], ex_regb_value[l]);
    end
  endtask

  // every lane of the id/ex register must hold a bubble
  task automatic check_bubble();
    for (int l = 0; l < `ID_WIDTH; l++) begin
      check_flag($sformatf("ex_valid[%0d]", l), 1'b0, ex_valid[l]);
    end
  endtask

  task automatic read_lane(input int l);
    int v, a, oa, ob, d, code;
    code = $fscanf(fd, "%d %h %h %d %d %d %d %h %h %h", v, e_inst[l], e_npc[l],
                   a, oa, ob, d, e_flags[l], e_rega[l], e_regb[l]);
    if (code != 10) begin
      errors++;
      $display("stimulus file has a malformed lane record for lane %0d", l);
    end
    e_in_valid[l] = (v != 0);
    e_alu[l]      = alu_func_e'(a);
    e_opa[l]      = opa_sel_e'(oa);
    e_opb[l]      = opb_sel_e'(ob);
    e_dest[l]     = IDX_W'(d);
  endtask

  task automatic present_bundle();
    for (int l = 0; l < `ID_WIDTH; l++) begin
      if_valid[l] = e_in_valid[l];
      if_inst[l]  = e_inst[l];
      if_npc[l]   = e_npc[l];
    end
  endtask

  task automatic finish_test(input string what);
    n_test++;
    if (errors == err_mark) begin
      n_pass++;
      $display("test %0d %s: pass", n_test, what);
    end else begin
      n_fail++;
      $display("test %0d %s: fail", n_test, what);
    end
    err_mark = errors;
  endtask

  //////////////////////////////////////////////////
  // stimulus actions start 1 ns after a rising edge
  task automatic write_reg(input logic [IDX_W-1:0] idx, input logic [`XLEN-1:0] data);
    wb_en   = 1'b1;
    wb_idx  = idx;
    wb_data = data;
    @(posedge clock);
    #1 wb_en = 1'b0;
  endtask

  task automatic run_bundle();
    int phase, cycles, hold;
    phase  = 0;
    cycles = 0;
    present_bundle();
    hold = stall_stretch();
    while (phase < 2 && cycles < 20) begin   // two unstalled edges to reach ex
      stall = (hold > 0);
      if (phase == 1 && !stall && byp_pend) begin
        wb_en    = 1'b1;                     // lands on the same edge as the capture
        wb_idx   = byp_idx;
        wb_data  = byp_data;
        byp_pend = 1'b0;
      end
      @(posedge clock);
      #1 wb_en = 1'b0;
      cycles++;
      if (hold > 0) begin
        hold--;
      end else begin
        phase++;
        if_valid = '0;                       // fetch moves on once captured
        hold = stall_stretch();
      end
      if (phase == 1) begin
        check_bubble();                      // no early arrival and no repeat of the last one
      end
    end
    stall = 1'b0;
    if (phase < 2) begin
      errors++;
      $display("timeout: bundle did not reach the id/ex register within 20 cycles");
    end else begin
      for (int l = 0; l < `ID_WIDTH; l++) check_lane(l);
    end
  endtask

  task automatic run_flush();
    present_bundle();
    stall = 1'b0;
    @(posedge clock);
    #1 if_valid = '0;
    flush = 1'b1;                            // bundle now sits in the fetch latch
    @(posedge clock);
    #1 flush = 1'b0;
    check_bubble();
    @(posedge clock);
    #1;
    check_bubble();
  endtask

  //////////////////////////////////////////////////
  initial begin
    string line;
    int    idx, code;
    logic [`XLEN-1:0] data;
    rst_n = 1'b0;
    {stall, flush, wb_en} = '0;
    if_valid = '0;
    if_inst  = '0;
    if_npc   = '0;
    wb_idx   = '0;
    wb_data  = '0;
    lfsr     = 32'h709e;
    {errors, n_test, n_pass, n_fail, err_mark} = '0;
    {byp_pend, flush_next} = '0;
    repeat (8) @(posedge clock);
    #1 rst_n = 1'b1;

    for (int l = 0; l < `ID_WIDTH; l++) begin  // reset leaves only bubbles
      check_flag($sformatf("ex_valid[%0d]", l), 1'b0, ex_valid[l]);
      check_flag($sformatf("ex_rd_mem[%0d]", l), 1'b0, ex_rd_mem[l]);
      check_flag($sformatf("ex_wr_mem[%0d]", l), 1'b0, ex_wr_mem[l]);
      check_flag($sformatf("ex_halt[%0d]", l), 1'b0, ex_halt[l]);
      check_flag($sformatf("ex_cond_branch[%0d]", l), 1'b0, ex_cond_branch[l]);
      check_flag($sformatf("ex_uncond_branch[%0d]", l), 1'b0, ex_uncond_branch[l]);
      check_flag($sformatf("ex_illegal[%0d]", l), 1'b0, ex_illegal[l]);
    end
    finish_test("reset");

    fd = $fopen("id_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stimulus file id_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        kind = '0;
        code = $fscanf(fd, "%s", kind);
        if (code != 1) break;
        if (kind == "#") begin
          code = $fgets(line, fd);           // skip the rest of a comment line
        end else if (kind == "W") begin
          code = $fscanf(fd, "%d %h", idx, data);
          write_reg(IDX_W'(idx), data);
        end else if (kind == "Y") begin
          code = $fscanf(fd, "%d %h", idx, data);
          byp_idx  = IDX_W'(idx);
          byp_data = data;
          byp_pend = 1'b1;
        end else if (kind == "F") begin
          flush_next = 1'b1;
        end else if (kind == "B") begin
          for (int l = 0; l < `ID_WIDTH; l++) read_lane(l);
          if (flush_next) begin
            run_flush();
            flush_next = 1'b0;
            finish_test("flush");
          end else begin
            run_bundle();
            finish_test($sformatf("bundle npc %h", e_npc[0]));
          end
        end else begin
          errors++;
          $display("unknown record kind in the stimulus file");
        end
      end
      $fclose(fd);
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d", n_test, n_pass, n_fail, errors);
    if (errors == 0 && n_fail == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
`default_nettype wire

// File: id_stimulus.txt
# records: W idx data | Y idx data (write during next decode) | F (flush next bundle) | B lane0 lane1
# lane: valid inst npc alu opa opb dest flags(ill cpuid halt ubr cbr stc ldl wr rd) rega regb
W 1 1111
W 2 2222
W 3 3333
W 4 4444
W 31 dead
B 1 40220405 1004 0 0 0 5 000 1111 2222
  1 406ff526 1008 1 0 1 6 000 3333 0
B 1 a4e10010 100c 0 0 2 7 001 1111 1111
  1 b4430008 1010 0 0 2 31 002 3333 2222
B 1 ad040000 1014 0 0 2 8 005 4444 4444
  1 bc220000 1018 0 0 2 31 00a 2222 1111
B 1 c3400005 101c 0 2 4 26 020 0 0
  1 d0200010 1020 0 2 4 1 020 1111 0
B 1 e4400003 1024 0 2 3 31 010 2222 0
  1 6b630000 1028 2 3 0 27 020 0 3333
B 1 00000000 102c 0 3 0 31 040 0 0
  1 0000003c 1030 0 3 0 31 080 0 0
B 1 04000000 1034 0 0 0 31 100 0 0
  1 40000fe5 1038 0 0 0 31 100 0 0
B 0 40220405 103c 0 0 0 31 000 0 0
  0 406ff526 1040 0 0 0 31 000 0 0
Y 10 abcd
B 1 43e10409 1044 0 0 0 9 000 0 1111
  1 414a040b 1048 0 0 0 11 000 abcd abcd
F
B 1 40220405 104c 0 0 0 5 000 1111 2222
  1 a4e10010 1050 0 0 2 7 001 1111 1111
B 1 21820020 1054 0 0 2 12 000 2222 2222
  0 00000000 1058 0 3 0 31 000 0 0

// File: alpha_id.f
+incdir+.
alpha_id_pkg.sv
fetch_latch.sv
inst_decoder.sv
regfile.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv
